/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_ofdm_equalizer
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* chan_est/chan_est.sv */
`timescale 1ns/1ps

module chan_est #(
    parameter int SAMPLE_W   = eq_pkg::SAMPLE_W,
    parameter int FFT_ADDR_W = eq_pkg::FFT_ADDR_W
) (
    input  logic                  clock,
    input  logic                  reset,
    input  eq_pkg::sample_t       sample_i,
    input  logic                  sample_valid_i,
    input  logic [FFT_ADDR_W-1:0] rd_index_i,
    output eq_pkg::sample_t       est_o,
    output logic                  est_ready_o
);

    eq_pkg::est_state_e state;
    logic [FFT_ADDR_W-1:0] in_cnt;
    logic take;

    // stage 1 of the LTS-2 path, lines up with the RAM read
    logic s1_vld;
    logic [FFT_ADDR_W-1:0] s1_addr;
    logic s1_neg;
    eq_pkg::sample_t s1_sample;

    // write port
    logic wr_en;
    logic [FFT_ADDR_W-1:0] wr_addr;
    eq_pkg::sample_t wr_data;

    eq_pkg::sample_t est_ram [eq_pkg::FFT_LEN];
    eq_pkg::sample_t ram_q;
    logic [FFT_ADDR_W-1:0] rd_addr;

    logic signed [SAMPLE_W-1:0] a_i, a_q, b_i, b_q;
    logic signed [SAMPLE_W:0] sum_i, sum_q;
    logic signed [SAMPLE_W-1:0] mean_i, mean_q;

    assign take = sample_valid_i && (state != eq_pkg::EST_DONE);

    // during LTS 2 the RAM is read back at the incoming index
    assign rd_addr = (state == eq_pkg::EST_DONE) ? rd_index_i : in_cnt;

    assign a_i = ram_q[2*SAMPLE_W-1:SAMPLE_W];
    assign a_q = ram_q[SAMPLE_W-1:0];
    assign b_i = s1_sample[2*SAMPLE_W-1:SAMPLE_W];
    assign b_q = s1_sample[SAMPLE_W-1:0];

    // sign extended sum, then halve by dropping the lsb
    assign sum_i = a_i + b_i;
    assign sum_q = a_q + b_q;
    assign mean_i = sum_i[SAMPLE_W:1];
    assign mean_q = sum_q[SAMPLE_W:1];

    assign est_o = ram_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= eq_pkg::EST_FIRST;
            in_cnt <= '0;
            s1_vld <= 1'b0;
            wr_en <= 1'b0;
            est_ready_o <= 1'b0;
        end else begin
            s1_vld <= take && (state == eq_pkg::EST_SECOND);
            // LTS 1 is written as it comes in
            wr_en <= (take && (state == eq_pkg::EST_FIRST)) || s1_vld;
            if (take) begin
                in_cnt <= in_cnt + 1'b1;
                if (&in_cnt) begin
                    state <= (state == eq_pkg::EST_FIRST) ? eq_pkg::EST_SECOND
                                                          : eq_pkg::EST_DONE;
                end
            end
            if ((state == eq_pkg::EST_DONE) && wr_en && (&wr_addr)) begin
                est_ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        s1_addr <= in_cnt;
        s1_sample <= sample_i;
        s1_neg <= eq_pkg::LTS_REF[in_cnt];
        if (s1_vld) begin
            wr_addr <= s1_addr;
            wr_data <= s1_neg ? {-mean_i, -mean_q} : {mean_i, mean_q};
        end else begin
            wr_addr <= in_cnt;
            wr_data <= sample_i;
        end
        if (wr_en) begin
            est_ram[wr_addr] <= wr_data;
        end
        ram_q <= est_ram[rd_addr];
    end

    // the last write of each LTS pass lands after the FSM has left EST_FIRST
    assert property (@(posedge clock) disable iff (reset)
        wr_en && (&wr_addr) |-> state != eq_pkg::EST_FIRST);

endmodule

/* common/eq_pkg.sv */
package eq_pkg;

    // rail and index widths
    localparam int SAMPLE_W = 16;
    localparam int FFT_ADDR_W = 6;
    localparam int FFT_LEN = 64;
    localparam int NUM_DATA_SC = 48;

    // divisor width, the low bits of the squared magnitude
    localparam int MAG_W = 24;

    // products go up by this shift plus one before the divide
    localparam int CONS_SCALE_SHIFT = 6;

    // one quotient bit per stage
    localparam int DIV_STAGES = 32;

    // bit 0 is DC, bits 1..26 are +1..+26, bits 38..63 are -26..-1
    localparam logic [63:0] LEGACY_SC_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    // pilots at -7, -21, +21, +7
    localparam logic [63:0] PILOT_SC_MASK =
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    localparam logic [63:0] DATA_SC_MASK = LEGACY_SC_MASK ^ PILOT_SC_MASK;

    // set bit means the long training value on that subcarrier is -1
    localparam logic [63:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    typedef enum logic [1:0] {
        EST_FIRST,
        EST_SECOND,
        EST_DONE
    } est_state_e;

    typedef logic signed [SAMPLE_W-1:0] rail_t;

    // I in the upper half, Q in the lower half
    typedef logic [2*SAMPLE_W-1:0] sample_t;

endpackage

/* list.f */
common/eq_pkg.sv
chan_est/chan_est.sv
logic/divider.sv
logic/sym_buffer.sv
logic/equalize.sv
logic/ofdm_equalizer.sv
tb/tb_ofdm_equalizer.sv

/* logic/divider.sv */
`timescale 1ns/1ps

module divider #(
    parameter int DIV_STAGES = eq_pkg::DIV_STAGES
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic signed [31:0]       dividend_i,
    input  logic [eq_pkg::MAG_W-1:0] divisor_i,
    input  logic                     valid_i,
    output logic signed [31:0]       quotient_o,
    output logic                     valid_o
);

    localparam int DVS_W = eq_pkg::MAG_W;

    logic [31:0] dvd_abs;
    logic [DVS_W-1:0] rem_q [DIV_STAGES];
    logic [31:0] dq_q [DIV_STAGES];
    logic [DVS_W-1:0] dvs_q [DIV_STAGES];
    logic [DIV_STAGES-1:0] neg_q;
    logic [DIV_STAGES-1:0] vld_q;

    // one restoring step, the remainder and the dividend shift as one word
    // and the quotient bit enters at the bottom
    function automatic logic [DVS_W+31:0] div_step(
        input logic [DVS_W-1:0] rem,
        input logic [31:0]      dq,
        input logic [DVS_W-1:0] dvs
    );
        logic [DVS_W:0] shifted;
        logic [DVS_W:0] diff;
        shifted = {rem, dq[31]};
        diff = shifted - {1'b0, dvs};
        if (diff[DVS_W]) begin
            return {shifted[DVS_W-1:0], dq[30:0], 1'b0};
        end else begin
            return {diff[DVS_W-1:0], dq[30:0], 1'b1};
        end
    endfunction

    assign dvd_abs = dividend_i[31] ? -dividend_i : dividend_i;

    always_ff @(posedge clock) begin
        {rem_q[0], dq_q[0]} <= div_step('0, dvd_abs, divisor_i);
        dvs_q[0] <= divisor_i;
        neg_q[0] <= dividend_i[31];
        for (int s = 1; s < DIV_STAGES; s++) begin
            {rem_q[s], dq_q[s]} <= div_step(rem_q[s-1], dq_q[s-1], dvs_q[s-1]);
            dvs_q[s] <= dvs_q[s-1];
            neg_q[s] <= neg_q[s-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[DIV_STAGES-2:0], valid_i};
        end
    end

    // magnitude division, sign put back so the result truncates toward zero
    assign quotient_o = neg_q[DIV_STAGES-1] ? -dq_q[DIV_STAGES-1] : dq_q[DIV_STAGES-1];
    assign valid_o = vld_q[DIV_STAGES-1];

    assert property (@(posedge clock) disable iff (reset)
        valid_i |-> divisor_i != '0);

endmodule

/* logic/equalize.sv */
`timescale 1ns/1ps

module equalize #(
    parameter int SAMPLE_W         = eq_pkg::SAMPLE_W,
    parameter int FFT_ADDR_W       = eq_pkg::FFT_ADDR_W,
    parameter int DIV_STAGES       = eq_pkg::DIV_STAGES,
    parameter int CONS_SCALE_SHIFT = eq_pkg::CONS_SCALE_SHIFT
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  rd_valid_i,
    input  logic [FFT_ADDR_W-1:0] rd_index_i,
    input  eq_pkg::sample_t       data_i,
    input  eq_pkg::sample_t       est_i,
    output eq_pkg::sample_t       sample_o,
    output logic                  sample_valid_o
);

    localparam int PROD_W = 2 * SAMPLE_W;

    logic read_vld;
    logic [FFT_ADDR_W-1:0] read_idx;
    logic signed [SAMPLE_W-1:0] y_i, y_q, e_i, e_q;
    logic signed [PROD_W-1:0] prod_i, prod_q, mag;

    logic mul_vld;
    logic [FFT_ADDR_W-1:0] mul_idx;
    logic signed [PROD_W-1:0] mul_i, mul_q;
    logic [eq_pkg::MAG_W-1:0] mul_mag;

    logic div_in_vld;
    logic signed [PROD_W-1:0] div_in_i, div_in_q;
    logic [eq_pkg::MAG_W-1:0] div_in_mag;

    logic signed [PROD_W-1:0] quot_i, quot_q;
    logic quot_vld;

    assign y_i = data_i[PROD_W-1:SAMPLE_W];
    assign y_q = data_i[SAMPLE_W-1:0];
    assign e_i = est_i[PROD_W-1:SAMPLE_W];
    assign e_q = est_i[SAMPLE_W-1:0];

    // y times conj(e)
    assign prod_i = y_i * e_i + y_q * e_q;
    assign prod_q = y_q * e_i - y_i * e_q;
    assign mag = e_i * e_i + e_q * e_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            read_vld <= 1'b0;
            mul_vld <= 1'b0;
            div_in_vld <= 1'b0;
            sample_valid_o <= 1'b0;
        end else begin
            read_vld <= rd_valid_i;
            mul_vld <= read_vld;
            // DC, pilots and guards stop here
            div_in_vld <= mul_vld && eq_pkg::DATA_SC_MASK[mul_idx];
            sample_valid_o <= quot_vld;
        end
    end

    always_ff @(posedge clock) begin
        read_idx <= rd_index_i;
        mul_idx <= read_idx;
        mul_i <= prod_i;
        mul_q <= prod_q;
        mul_mag <= mag[eq_pkg::MAG_W-1:0];
        div_in_i <= mul_i <<< (CONS_SCALE_SHIFT + 1);
        div_in_q <= mul_q <<< (CONS_SCALE_SHIFT + 1);
        div_in_mag <= mul_mag;
        // keep the sign and the low bits of each quotient
        sample_o <= {quot_i[PROD_W-1], quot_i[SAMPLE_W-2:0],
                     quot_q[PROD_W-1], quot_q[SAMPLE_W-2:0]};
    end

    divider #(
        .DIV_STAGES(DIV_STAGES)
    ) i_div_i (
        .clock     (clock),
        .reset     (reset),
        .dividend_i(div_in_i),
        .divisor_i (div_in_mag),
        .valid_i   (div_in_vld),
        .quotient_o(quot_i),
        .valid_o   (quot_vld)
    );

    // same strobe as the I rail
    divider #(
        .DIV_STAGES(DIV_STAGES)
    ) i_div_q (
        .clock     (clock),
        .reset     (reset),
        .dividend_i(div_in_q),
        .divisor_i (div_in_mag),
        .valid_i   (div_in_vld),
        .quotient_o(quot_q),
        .valid_o   ()
    );

endmodule

/* logic/ofdm_equalizer.sv */
`timescale 1ns/1ps

module ofdm_equalizer #(
    parameter int SAMPLE_W         = eq_pkg::SAMPLE_W,
    parameter int FFT_ADDR_W       = eq_pkg::FFT_ADDR_W,
    parameter int DIV_STAGES       = eq_pkg::DIV_STAGES,
    parameter int CONS_SCALE_SHIFT = eq_pkg::CONS_SCALE_SHIFT
) (
    input  logic            clock,
    input  logic            reset,
    input  eq_pkg::sample_t sample_i,
    input  logic            sample_valid_i,
    output eq_pkg::sample_t sample_o,
    output logic            sample_valid_o,
    output logic            est_ready_o
);

    logic rd_valid;
    logic [FFT_ADDR_W-1:0] rd_index;
    eq_pkg::sample_t rd_sample;
    eq_pkg::sample_t est;

    chan_est #(
        .SAMPLE_W  (SAMPLE_W),
        .FFT_ADDR_W(FFT_ADDR_W)
    ) i_chan_est (
        .clock         (clock),
        .reset         (reset),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .rd_index_i    (rd_index),
        .est_o         (est),
        .est_ready_o   (est_ready_o)
    );

    // data symbols are only taken once the estimate is complete
    sym_buffer #(
        .FFT_ADDR_W(FFT_ADDR_W)
    ) i_sym_buffer (
        .clock         (clock),
        .reset         (reset),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .est_ready_i   (est_ready_o),
        .rd_valid_o    (rd_valid),
        .rd_index_o    (rd_index),
        .rd_sample_o   (rd_sample)
    );

    equalize #(
        .SAMPLE_W        (SAMPLE_W),
        .FFT_ADDR_W      (FFT_ADDR_W),
        .DIV_STAGES      (DIV_STAGES),
        .CONS_SCALE_SHIFT(CONS_SCALE_SHIFT)
    ) i_equalize (
        .clock         (clock),
        .reset         (reset),
        .rd_valid_i    (rd_valid),
        .rd_index_i    (rd_index),
        .data_i        (rd_sample),
        .est_i         (est),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o)
    );

endmodule

/* logic/sym_buffer.sv */
`timescale 1ns/1ps

module sym_buffer #(
    parameter int FFT_ADDR_W = eq_pkg::FFT_ADDR_W
) (
    input  logic                  clock,
    input  logic                  reset,
    input  eq_pkg::sample_t       sample_i,
    input  logic                  sample_valid_i,
    input  logic                  est_ready_i,
    output logic                  rd_valid_o,
    output logic [FFT_ADDR_W-1:0] rd_index_o,
    output eq_pkg::sample_t       rd_sample_o
);

    logic wr_en;
    logic wr_bank;
    logic [FFT_ADDR_W-1:0] wr_idx;
    logic [1:0] full;
    logic rd_bank;
    logic fill_done;
    logic rd_last;
    logic next_bank;
    logic next_ready;

    eq_pkg::sample_t buf_ram [2*eq_pkg::FFT_LEN];

    assign wr_en = sample_valid_i && est_ready_i;
    assign fill_done = wr_en && (&wr_idx);
    assign rd_last = rd_valid_o && (&rd_index_o);

    // bank to replay next, which may be the one completing this cycle
    assign next_bank = rd_last ? ~rd_bank : rd_bank;
    assign next_ready = full[next_bank] || (fill_done && (wr_bank == next_bank));

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_bank <= 1'b0;
            wr_idx <= '0;
            full <= '0;
            rd_bank <= 1'b0;
            rd_valid_o <= 1'b0;
            rd_index_o <= '0;
        end else begin
            if (wr_en) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (rd_valid_o) begin
                rd_index_o <= rd_index_o + 1'b1;
            end
            if (rd_last) begin
                full[rd_bank] <= 1'b0;
                rd_bank <= next_bank;
            end
            if (fill_done) begin
                full[wr_bank] <= 1'b1;
                wr_bank <= ~wr_bank;
            end
            // back to back replays when the other bank is already waiting
            if (!rd_valid_o || rd_last) begin
                rd_valid_o <= next_ready;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            buf_ram[{wr_bank, wr_idx}] <= sample_i;
        end
        rd_sample_o <= buf_ram[{rd_bank, rd_index_o}];
    end

    // the replay must free a bank before the writer comes round to it
    assert property (@(posedge clock) disable iff (reset)
        wr_en |-> !full[wr_bank]);

endmodule

/* tb/eq_patterns.txt */
# subcarrier lts1 lts2 data expected, all hex
# samples are {I, Q} with 16 bits each
01 01000000 01000000 00400020 00200010
02 FF000000 FF000000 00400020 00200010
03 01000000 01000000 01000080 FF80FFC0
04 00000100 00000100 00400020 0010FFE0
05 01000000 01020000 04000000 01FE0000
06 01000000 01000000 0003FFFD FFFF0001
26 00800000 00800000 00100030 00100030
3F 01000000 01000000 FF80FF00 FFC0FF80

/* tb/tb_ofdm_equalizer.sv */
`timescale 1ns/1ps

module tb_ofdm_equalizer;

    logic            clock;
    logic            reset;
    eq_pkg::sample_t sample_i;
    logic            sample_valid_i;
    eq_pkg::sample_t sample_o;
    logic            sample_valid_o;
    logic            est_ready_o;

    int errors;
    int checks;
    bit aborted;
    eq_pkg::sample_t lts1 [64];
    eq_pkg::sample_t lts2 [64];
    eq_pkg::sample_t est [64];
    eq_pkg::sample_t cur_sym [64];
    eq_pkg::sample_t file_lts1 [64];
    eq_pkg::sample_t file_lts2 [64];
    eq_pkg::sample_t file_data [64];
    eq_pkg::sample_t file_exp [64];
    logic [63:0] file_has;
    eq_pkg::sample_t exp_q [$];
    eq_pkg::sample_t got_q [$];

    ofdm_equalizer i_ofdm_equalizer (
        .clock         (clock),
        .reset         (reset),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .sample_o      (sample_o),
        .sample_valid_o(sample_valid_o),
        .est_ready_o   (est_ready_o)
    );

    always #10 clock = ~clock;

    // outputs are collected away from the driving edge
    always @(negedge clock) begin
        if (!reset && sample_valid_o) begin
            got_q.push_back(sample_o);
        end
    end

    // signed mean of the two LTS symbols with the reference sign applied
    function automatic eq_pkg::sample_t mean_est(eq_pkg::sample_t a, eq_pkg::sample_t b, int k);
        eq_pkg::rail_t ai, aq, bi, bq, ei, eq;
        logic signed [16:0] si, sq;
        ai = a[31:16];
        aq = a[15:0];
        bi = b[31:16];
        bq = b[15:0];
        si = ai + bi;
        sq = aq + bq;
        ei = si[16:1];
        eq = sq[16:1];
        if (eq_pkg::LTS_REF[k]) begin
            ei = -ei;
            eq = -eq;
        end
        return {ei, eq};
    endfunction

    // y times conj(e), scaled, divided by |e|^2 and packed
    function automatic eq_pkg::sample_t model_out(eq_pkg::sample_t y, eq_pkg::sample_t e);
        eq_pkg::rail_t yi, yq, ei, eq;
        logic signed [31:0] pi, pq;
        logic [23:0] mag;
        longint di, dq, md, qi, qq;
        yi = y[31:16];
        yq = y[15:0];
        ei = e[31:16];
        eq = e[15:0];
        pi = yi * ei + yq * eq;
        pq = yq * ei - yi * eq;
        pi = pi <<< (eq_pkg::CONS_SCALE_SHIFT + 1);
        pq = pq <<< (eq_pkg::CONS_SCALE_SHIFT + 1);
        mag = ei * ei + eq * eq;
        di = pi;
        dq = pq;
        md = mag;
        qi = di / md;
        qq = dq / md;
        return {qi[31], qi[14:0], qq[31], qq[14:0]};
    endfunction

    function automatic eq_pkg::rail_t rand_rail(int limit);
        int v;
        v = int'($urandom_range(2 * limit, 0)) - limit;
        return eq_pkg::rail_t'(v);
    endfunction

    task automatic check_sample(string name, eq_pkg::sample_t exp, eq_pkg::sample_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_count(string name, int exp, int got);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error: %s expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic end_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic load_patterns();
        int fd;
        int n;
        int k;
        string line;
        logic [31:0] l1, l2, d, e;
        file_has = '0;
        fd = $fopen("tb/eq_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            aborted = 1'b1;
            $display("could not open the patterns file tb/eq_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not parse into five fields
                n = $sscanf(line, "%h %h %h %h %h", k, l1, l2, d, e);
                if (n == 5 && k >= 0 && k < 64) begin
                    file_has[k] = 1'b1;
                    file_lts1[k] = l1;
                    file_lts2[k] = l2;
                    file_data[k] = d;
                    file_exp[k] = e;
                end
            end
            $fclose(fd);
        end
    endtask

    // random channel per subcarrier, LTS values carry the reference sign
    task automatic make_packet(bit use_file);
        eq_pkg::rail_t hi, hq;
        for (int k = 0; k < 64; k++) begin
            do begin
                hi = rand_rail(2047);
                hq = rand_rail(2047);
                lts1[k] = eq_pkg::LTS_REF[k] ? {-hi, -hq} : {hi, hq};
                lts2[k] = {lts1[k][31:16] + rand_rail(4), lts1[k][15:0] + rand_rail(4)};
                est[k] = mean_est(lts1[k], lts2[k], k);
            end while (est[k] == '0);
            if (use_file && file_has[k]) begin
                lts1[k] = file_lts1[k];
                lts2[k] = file_lts2[k];
                est[k] = mean_est(lts1[k], lts2[k], k);
            end
        end
    endtask

    task automatic send_sample(eq_pkg::sample_t s, int gap);
        repeat (gap) begin
            @(posedge clock);
            sample_valid_i <= 1'b0;
        end
        @(posedge clock);
        sample_i <= s;
        sample_valid_i <= 1'b1;
    endtask

    task automatic stop_drive();
        @(posedge clock);
        sample_valid_i <= 1'b0;
    endtask

    task automatic send_lts(int max_gap);
        for (int k = 0; k < 64; k++) begin
            send_sample(lts1[k], $urandom_range(max_gap, 0));
        end
        for (int k = 0; k < 64; k++) begin
            send_sample(lts2[k], $urandom_range(max_gap, 0));
        end
        stop_drive();
    endtask

    task automatic wait_est_ready();
        int cnt;
        cnt = 0;
        while (!est_ready_o && cnt < 200) begin
            @(negedge clock);
            cnt++;
        end
        if (!est_ready_o) begin
            errors++;
            aborted = 1'b1;
            $display("timeout: the channel estimate never became ready");
        end
    endtask

    // new random data symbol, file values where listed, expected outputs queued
    task automatic send_symbol(bit use_file, int max_gap);
        for (int k = 0; k < 64; k++) begin
            cur_sym[k] = {rand_rail(2047), rand_rail(2047)};
            if (use_file && file_has[k]) begin
                cur_sym[k] = file_data[k];
            end
            if (eq_pkg::DATA_SC_MASK[k]) begin
                exp_q.push_back((use_file && file_has[k]) ? file_exp[k]
                                                          : model_out(cur_sym[k], est[k]));
            end
        end
        for (int k = 0; k < 64; k++) begin
            send_sample(cur_sym[k], (max_gap > 0) ? $urandom_range(max_gap, 0) : 0);
        end
    endtask

    task automatic check_phase(string name, int symbols);
        int cnt;
        cnt = 0;
        while (got_q.size() < exp_q.size() && cnt < 3000) begin
            @(negedge clock);
            cnt++;
        end
        if (got_q.size() < exp_q.size()) begin
            errors++;
            aborted = 1'b1;
            $display("timeout: %s got %0d of %0d outputs", name, got_q.size(), exp_q.size());
        end else begin
            // extra outputs would show up within one pipeline flush
            repeat (120) @(negedge clock);
            check_count({name, " output count"}, symbols * eq_pkg::NUM_DATA_SC, got_q.size());
            for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
                check_sample($sformatf("%s sample_o[%0d]", name, i), exp_q[i], got_q[i]);
            end
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic run_packets();
        make_packet(1'b1);
        send_lts(0);
        wait_est_ready();
        if (aborted) return;

        send_symbol(1'b1, 0);
        stop_drive();
        check_phase("directed", 1);
        if (aborted) return;

        for (int s = 0; s < 4; s++) begin
            send_symbol(1'b0, 0);
        end
        stop_drive();
        check_phase("back_to_back", 4);
        if (aborted) return;

        for (int s = 0; s < 3; s++) begin
            send_symbol(1'b0, 3);
        end
        stop_drive();
        check_phase("gappy", 3);
        if (aborted) return;

        // this symbol is still in the pipe when the reset hits
        send_symbol(1'b0, 0);
        stop_drive();
        repeat (20) @(posedge clock);
        exp_q.delete();

        // second packet after a reset
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        repeat (120) begin
            @(negedge clock);
            check_bit("sample_valid_o", 1'b0, sample_valid_o);
            check_bit("est_ready_o", 1'b0, est_ready_o);
        end
        make_packet(1'b0);
        send_lts(2);
        wait_est_ready();
        if (aborted) return;
        for (int s = 0; s < 2; s++) begin
            send_symbol(1'b0, 1);
        end
        stop_drive();
        check_phase("second_packet", 2);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        sample_i = '0;
        sample_valid_i = 1'b0;
        errors = 0;
        checks = 0;
        aborted = 1'b0;
        void'($urandom(32'heea1));
        load_patterns();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        if (!aborted) begin
            run_packets();
        end
        end_run();
    end

endmodule
